/* Makefile */
# Verilator build and run for the RV32M multiply unit

TOOL       := verilator
TOP        := tb_mul_unit
FLIST      := flist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := ALL CHECKS PASSED
FLAGS      := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FLIST)

# Pass or fail comes from the log, not the simulator exit status
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
hw/mul_pkg.sv
hw/mul_stage_if.sv
hw/mul_operand_prep.sv
hw/mul_adder_tree.sv
hw/mul_result_sel.sv
hw/mul_unit_top.sv
testbench/mul_unit_sva.sv
testbench/tb_mul_unit.sv

/* hw/mul_adder_tree.sv */
// Pipelined unsigned multiplier
// Sums 32 shifted partial products pairwise over five registered
// levels and delays the request sideband to match

`timescale 1ns/1ps

module mul_adder_tree import mul_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	mul_stage_if.snk  i_stage,
	mul_stage_if.src  o_stage
);

	// One shifted copy of a per set bit of b
	logic [PROD_W-1:0] pp [XLEN];

	// Sideband delay line, one entry per tree level
	logic              valid_sr  [TREE_STAGES];
	mul_op_t           op_sr     [TREE_STAGES];
	logic              negate_sr [TREE_STAGES];
	logic [TAG_W-1:0]  tag_sr    [TREE_STAGES];

	genvar gi;
	genvar lv;

	for (gi = 0; gi < XLEN; gi++) begin : g_pp
		assign pp[gi] = i_stage.b_mag[gi] ?
			(PROD_W'(i_stage.a_mag) << gi) : '0;
	end

	// Level lv holds XLEN >> (lv + 1) sums, the last level a single one
	for (lv = 0; lv < TREE_STAGES; lv++) begin : g_level
		localparam int NODES = XLEN >> (lv + 1);

		logic [PROD_W-1:0] src [2 * NODES];
		logic [PROD_W-1:0] sum [NODES];

		if (lv == 0) begin : g_leaf
			assign src = pp;
		end else begin : g_inner
			assign src = g_level[lv-1].sum;
		end

		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				for (int n = 0; n < NODES; n++) begin
					sum[n] <= '0;
				end
			end else begin
				for (int n = 0; n < NODES; n++) begin
					sum[n] <= src[2*n] + src[2*n+1];
				end
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int s = 0; s < TREE_STAGES; s++) begin
				valid_sr[s]  <= 1'b0;
				op_sr[s]     <= MUL_LO;
				negate_sr[s] <= 1'b0;
				tag_sr[s]    <= '0;
			end
		end else begin
			valid_sr[0]  <= i_stage.valid;
			op_sr[0]     <= i_stage.op;
			negate_sr[0] <= i_stage.negate;
			tag_sr[0]    <= i_stage.tag;
			for (int s = 1; s < TREE_STAGES; s++) begin
				valid_sr[s]  <= valid_sr[s-1];
				op_sr[s]     <= op_sr[s-1];
				negate_sr[s] <= negate_sr[s-1];
				tag_sr[s]    <= tag_sr[s-1];
			end
		end
	end

	assign o_stage.valid   = valid_sr[TREE_STAGES-1];
	assign o_stage.op      = op_sr[TREE_STAGES-1];
	assign o_stage.negate  = negate_sr[TREE_STAGES-1];
	assign o_stage.tag     = tag_sr[TREE_STAGES-1];
	assign o_stage.product = g_level[TREE_STAGES-1].sum[0];

	// Magnitudes end here, later stages only need the product
	assign o_stage.a_mag = '0;
	assign o_stage.b_mag = '0;

endmodule

/* hw/mul_operand_prep.sv */
// Multiply operand preparation
// Registers the request, picks operand signedness from the opcode
// and converts operands to unsigned magnitudes plus a negate flag

`timescale 1ns/1ps

module mul_operand_prep import mul_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_valid,
	input  mul_op_t           i_op,
	input  logic [XLEN-1:0]   i_a,
	input  logic [XLEN-1:0]   i_b,
	input  logic [TAG_W-1:0]  i_rd,
	mul_stage_if.src          o_stage
);

	logic             a_signed;
	logic             b_signed;
	logic             a_neg;
	logic             b_neg;
	logic [XLEN-1:0]  a_mag;
	logic [XLEN-1:0]  b_mag;

	// MUL uses signed treatment too, the low word does not change
	assign a_signed = (i_op != MUL_HUU);
	assign b_signed = (i_op == MUL_LO) || (i_op == MUL_HSS);

	assign a_neg = a_signed & i_a[XLEN-1];
	assign b_neg = b_signed & i_b[XLEN-1];

	// Most negative value maps onto its own bit pattern as unsigned
	assign a_mag = a_neg ? (~i_a + 1'b1) : i_a;
	assign b_mag = b_neg ? (~i_b + 1'b1) : i_b;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_stage.valid  <= 1'b0;
			o_stage.op     <= MUL_LO;
			o_stage.negate <= 1'b0;
			o_stage.tag    <= '0;
			o_stage.a_mag  <= '0;
			o_stage.b_mag  <= '0;
		end else begin
			o_stage.valid  <= i_valid;
			o_stage.op     <= i_op;
			o_stage.negate <= a_neg ^ b_neg;
			o_stage.tag    <= i_rd;
			o_stage.a_mag  <= a_mag;
			o_stage.b_mag  <= b_mag;
		end
	end

	// No product exists yet at this point
	assign o_stage.product = '0;

endmodule

/* hw/mul_pkg.sv */
// RV32M multiply unit shared definitions
// Opcode encoding, datapath widths and pipeline depth constants

package mul_pkg;

	// Follows the low two bits of the RV32M funct3 field
	typedef enum logic [1:0] {
		MUL_LO  = 2'd0,
		MUL_HSS = 2'd1,
		MUL_HSU = 2'd2,
		MUL_HUU = 2'd3
	} mul_op_t;

	// Operand and result width
	localparam int XLEN = 32;

	// Full product width
	localparam int PROD_W = 2 * XLEN;

	// Destination register tag
	localparam int TAG_W = 5;

	// Pipeline depth per section
	localparam int PREP_STAGES = 1;
	localparam int TREE_STAGES = 5;
	localparam int SEL_STAGES  = 1;

	// Accepted request to valid result, in cycles
	localparam int MUL_LATENCY = PREP_STAGES + TREE_STAGES + SEL_STAGES;

endpackage

/* hw/mul_result_sel.sv */
// Multiply result select
// Restores the product sign and registers the low or high word
// together with the destination tag

`timescale 1ns/1ps

module mul_result_sel import mul_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	mul_stage_if.snk          i_stage,
	output logic              o_valid,
	output logic [XLEN-1:0]   o_result,
	output logic [TAG_W-1:0]  o_rd
);

	logic [PROD_W-1:0]  signed_prod;
	logic [XLEN-1:0]    word;

	// Two's complement of the full 64-bit magnitude product
	assign signed_prod = i_stage.negate ? (~i_stage.product + 1'b1) : i_stage.product;

	always_comb begin
		if (i_stage.op == MUL_LO) begin
			word = signed_prod[XLEN-1:0];
		end else begin
			// MULH, MULHSU and MULHU all take the upper half
			word = signed_prod[PROD_W-1:XLEN];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_valid  <= 1'b0;
			o_result <= '0;
			o_rd     <= '0;
		end else begin
			o_valid  <= i_stage.valid;
			o_result <= word;
			o_rd     <= i_stage.tag;
		end
	end

endmodule

/* hw/mul_stage_if.sv */
// Multiply pipeline stage link
// Carries one in-flight multiply and its sideband between two stages

`timescale 1ns/1ps

interface mul_stage_if import mul_pkg::*; ();

	logic               valid;
	mul_op_t            op;
	logic               negate;
	logic [TAG_W-1:0]   tag;
	logic [XLEN-1:0]    a_mag;
	logic [XLEN-1:0]    b_mag;
	logic [PROD_W-1:0]  product;

	// Upstream stage drives everything
	modport src (
		output valid, op, negate, tag, a_mag, b_mag, product
	);

	// Downstream stage only samples
	modport snk (
		input valid, op, negate, tag, a_mag, b_mag, product
	);

endinterface

/* hw/mul_unit_top.sv */
// RV32M multiply unit
// Operand prep, pipelined adder tree and result select, one request
// per clock with a fixed seven cycle latency

`timescale 1ns/1ps

module mul_unit_top import mul_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_valid,
	input  logic [1:0]        i_op,
	input  logic [XLEN-1:0]   i_a,
	input  logic [XLEN-1:0]   i_b,
	input  logic [TAG_W-1:0]  i_rd,
	output logic              o_valid,
	output logic [XLEN-1:0]   o_result,
	output logic [TAG_W-1:0]  o_rd
);

	mul_stage_if prep_to_tree ();
	mul_stage_if tree_to_sel ();

	mul_op_t op;

	// Raw funct3 bits onto the opcode type
	assign op = mul_op_t'(i_op);

	mul_operand_prep mul_operand_prep_i (
		.clk     (clk),
		.rst     (rst),
		.i_valid (i_valid),
		.i_op    (op),
		.i_a     (i_a),
		.i_b     (i_b),
		.i_rd    (i_rd),
		.o_stage (prep_to_tree.src)
	);

	mul_adder_tree mul_adder_tree_i (
		.clk     (clk),
		.rst     (rst),
		.i_stage (prep_to_tree.snk),
		.o_stage (tree_to_sel.src)
	);

	mul_result_sel mul_result_sel_i (
		.clk      (clk),
		.rst      (rst),
		.i_stage  (tree_to_sel.snk),
		.o_valid  (o_valid),
		.o_result (o_result),
		.o_rd     (o_rd)
	);

endmodule

/* testbench/mul_testdata.hex */
// One multiply per line: opcode, operand a, operand b, expected 32-bit result
// Opcode 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU; every field in hex
0 00000003 00000005 0000000f
0 fffffffd 00000005 fffffff1
0 00000007 fffffffa ffffffd6
0 fffffff9 fffffffa 0000002a
0 00000000 12345678 00000000
0 deadbeef 00000000 00000000
0 80000000 80000000 00000000
0 ffffffff ffffffff 00000001
0 00010000 00010000 00000000
0 0000ffff 0000ffff fffe0001
0 12345678 00000010 23456780
0 7fffffff 00000002 fffffffe
1 80000000 80000000 40000000
1 ffffffff ffffffff 00000000
1 7fffffff 80000000 c0000000
1 80000000 7fffffff c0000000
1 ffffffff 00000001 ffffffff
1 7fffffff 7fffffff 3fffffff
1 00000003 00000005 00000000
1 fffffffd 00000005 ffffffff
1 00010000 00010000 00000001
1 ffff0000 00010000 ffffffff
1 c0000000 c0000000 10000000
2 ffffffff ffffffff ffffffff
2 80000000 ffffffff 80000000
2 7fffffff ffffffff 7ffffffe
2 00000002 80000000 00000001
2 fffffffe 80000000 ffffffff
2 00000000 ffffffff 00000000
2 ffffffff 00000001 ffffffff
2 00000001 ffffffff 00000000
3 ffffffff ffffffff fffffffe
3 80000000 80000000 40000000
3 00000002 80000000 00000001
3 ffffffff 00000002 00000001
3 12345678 00000000 00000000
3 00010000 00010000 00000001

/* testbench/mul_unit_sva.sv */
// Multiply unit protocol assertions
// Fixed result latency and quiet outputs out of reset

`timescale 1ns/1ps

module mul_unit_sva import mul_pkg::*; (
	input logic clk,
	input logic rst,
	input logic i_valid,
	input logic o_valid
);

	// Nothing can be in flight on the first edge after reset release
	property quiet_after_reset;
		@(posedge clk) $fell(rst) |-> !o_valid;
	endproperty

	property result_follows_request;
		@(posedge clk) disable iff (rst) i_valid |-> ##MUL_LATENCY o_valid;
	endproperty

	// Every result must trace back to a request
	property result_has_request;
		@(posedge clk) disable iff (rst) o_valid |-> $past(i_valid, MUL_LATENCY);
	endproperty

	a_quiet_after_reset: assert property (quiet_after_reset)
		else $error("o_valid high on the first cycle after reset release");

	a_result_follows_request: assert property (result_follows_request)
		else $error("request accepted but o_valid missing after the fixed latency");

	a_result_has_request: assert property (result_has_request)
		else $error("o_valid high without a request at the matching earlier cycle");

endmodule

bind mul_unit_top mul_unit_sva mul_unit_sva_i (
	.clk     (clk),
	.rst     (rst),
	.i_valid (i_valid),
	.o_valid (o_valid)
);

/* testbench/tb_mul_unit.sv */
// RV32M multiply unit testbench
// Runs directed vectors from the data file and then random requests with gaps
// and checks every result word, tag and arrival cycle

`timescale 1ns/1ps

module tb_mul_unit import mul_pkg::*; ();

	localparam int N_DIRECTED     = 37;
	localparam int N_RANDOM       = 200;
	localparam int IDLE_CYCLES    = 10;
	localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM + MUL_LATENCY) * 2 + 50;

	typedef struct {
		logic [XLEN-1:0]   result;
		logic [TAG_W-1:0]  rd;
		int                due;
	} expect_t;

	logic              clk;
	logic              rst;
	logic              i_valid;
	logic [1:0]        i_op;
	logic [XLEN-1:0]   i_a;
	logic [XLEN-1:0]   i_b;
	logic [TAG_W-1:0]  i_rd;
	logic              o_valid;
	logic [XLEN-1:0]   o_result;
	logic [TAG_W-1:0]  o_rd;

	// Four words per vector for opcode, a, b and expected
	logic [XLEN-1:0] vec_mem [4*N_DIRECTED];

	expect_t exp_q [$];
	int cyc    = 0;
	int errors = 0;
	int n_req  = 0;
	int n_out  = 0;

	mul_unit_top mul_unit_top_i (
		.clk      (clk),
		.rst      (rst),
		.i_valid  (i_valid),
		.i_op     (i_op),
		.i_a      (i_a),
		.i_b      (i_b),
		.i_rd     (i_rd),
		.o_valid  (o_valid),
		.o_result (o_result),
		.o_rd     (o_rd)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// Reference model that sign or zero extends to 64 bits and picks a word
	function automatic logic [XLEN-1:0] expected_word(input mul_op_t op,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [PROD_W-1:0] a_ext;
		logic [PROD_W-1:0] b_ext;
		logic [PROD_W-1:0] prod;
		a_ext = (op == MUL_HUU) ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN-1]}}, a};
		b_ext = (op == MUL_HSS) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
		prod  = a_ext * b_ext;
		if (op == MUL_LO) begin
			return prod[XLEN-1:0];
		end
		return prod[PROD_W-1:XLEN];
	endfunction

	// Mostly random with corner values now and then
	function automatic logic [XLEN-1:0] pick_operand();
		logic [XLEN-1:0] corners [5];
		corners[0] = 32'h0000_0000;
		corners[1] = 32'h0000_0001;
		corners[2] = 32'hffff_ffff;
		corners[3] = 32'h8000_0000;
		corners[4] = 32'h7fff_ffff;
		if (($urandom % 8) == 0) begin
			return corners[$urandom % 5];
		end
		return $urandom;
	endfunction

	// Request is sampled by the DUT on the edge after it is driven
	task automatic send_request(input logic [1:0] op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b, input logic [XLEN-1:0] expected);
		expect_t e;
		@(posedge clk);
		#1;
		i_valid = 1'b1;
		i_op    = op;
		i_a     = a;
		i_b     = b;
		i_rd    = TAG_W'(n_req % 32);
		e.result = expected;
		e.rd     = i_rd;
		e.due    = cyc + 1 + MUL_LATENCY;
		exp_q.push_back(e);
		n_req++;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			i_valid = 1'b0;
		end
	endtask

	task automatic wait_for_drain();
		idle_cycles(1);
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic report_test(input string name, input int reqs, input int errs);
		$display("test %-12s %4d requests, %0d errors", name, reqs, errs);
	endtask

	task automatic run_directed(input logic [1:0] op, input string name);
		int err0;
		int req0;
		err0 = errors;
		req0 = n_req;
		for (int v = 0; v < N_DIRECTED; v++) begin
			if (vec_mem[4*v][1:0] == op) begin
				send_request(op, vec_mem[4*v+1], vec_mem[4*v+2], vec_mem[4*v+3]);
			end
		end
		wait_for_drain();
		report_test(name, n_req - req0, errors - err0);
	endtask

	task automatic run_random();
		int err0;
		int req0;
		logic [1:0] op;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		err0 = errors;
		req0 = n_req;
		for (int k = 0; k < N_RANDOM; k++) begin
			op = 2'($urandom % 4);
			a  = pick_operand();
			b  = pick_operand();
			if (($urandom % 4) == 0) begin
				idle_cycles(1 + ($urandom % 2));
			end
			send_request(op, a, b, expected_word(mul_op_t'(op), a, b));
		end
		wait_for_drain();
		report_test("random_gaps", n_req - req0, errors - err0);
	endtask

	// Outputs read here were registered on the previous edge
	always @(posedge clk) begin
		expect_t e;
		cyc = cyc + 1;
		while (exp_q.size() != 0 && exp_q[0].due < cyc) begin
			e = exp_q.pop_front();
			$display("no result for tag %0d by cycle %0d", e.rd, e.due);
			errors++;
		end
		if (o_valid === 1'b1) begin
			n_out++;
			if (exp_q.size() == 0) begin
				$display("o_valid high at cycle %0d with no request outstanding", cyc);
				errors++;
			end else begin
				e = exp_q.pop_front();
				if (cyc != e.due) begin
					$display("result for tag %0d arrived at cycle %0d instead of %0d",
						e.rd, cyc, e.due);
					errors++;
				end
				if (o_result !== e.result) begin
					$display("mismatch o_result: tag %0d got %h expected %h",
						e.rd, o_result, e.result);
					errors++;
				end
				if (o_rd !== e.rd) begin
					$display("mismatch o_rd: got %h expected %h", o_rd, e.rd);
					errors++;
				end
			end
		end
	end

	initial begin
		while (cyc < TIMEOUT_CYCLES) begin
			@(negedge clk);
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		int err0;
		rst     = 1'b1;
		i_valid = 1'b0;
		i_op    = 2'd0;
		i_a     = '0;
		i_b     = '0;
		i_rd    = '0;
		void'($urandom(4));
		$readmemh("testbench/mul_testdata.hex", vec_mem);
		if (vec_mem[4*N_DIRECTED-1] === 'x) begin
			$display("test data file is missing or holds too few vectors");
			errors++;
		end

		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// Outputs must stay quiet until the first request comes through
		err0 = errors;
		idle_cycles(IDLE_CYCLES);
		if (n_out != 0) begin
			$display("o_valid went high during the idle window after reset");
			errors++;
		end
		report_test("reset_idle", 0, errors - err0);

		run_directed(2'd0, "mul");
		run_directed(2'd1, "mulh");
		run_directed(2'd2, "mulhsu");
		run_directed(2'd3, "mulhu");
		run_random();

		if (n_out != n_req) begin
			$display("result count %0d does not match request count %0d", n_out, n_req);
			errors++;
		end

		$display("%0d requests, %0d results, %0d errors", n_req, n_out, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
